// File: src/fpu_pkg.sv
package fpu_pkg;

   // ieee single layout
   localparam int exp_width  = 8;
   localparam int frac_width = 23;
   localparam int exp_bias   = 127;

   localparam int inter_exp_width = 10;   // signed biased exp, headroom for of/uf
   localparam int inter_man_width = 27;   // carry, hidden, 23 frac, guard, round

   localparam logic [31:0] canonical_nan = 32'h7fc00000;   // quiet nan

   // funct7 encodings
   typedef enum logic [6:0] {
      op_add     = 7'b0100000,
      op_sub     = 7'b0100100,
      op_mul     = 7'b0000010,
      op_invalid = 7'b1111111    // any other funct7
   } fpu_op_e;

   typedef enum logic [1:0] {
      cls_zero,      // also flushed subnormals
      cls_normal,
      cls_inf,
      cls_nan
   } fp_class_e;

   // unit result before normalize/round
   typedef struct packed {
      logic                              sign;
      fp_class_e                         cls;
      logic signed [inter_exp_width-1:0] exponent;      // biased, hidden bit at [25]
      logic [inter_man_width-1:0]        significand;
      logic                              sticky;        // or of bits below round
      logic                              invalid;       // inf-inf, inf*0
   } fp_inter_t;

   // bit 4 down to bit 0
   typedef struct packed {
      logic nv;
      logic dz;   // no divider here
      logic of;
      logic uf;
      logic nx;
   } fpu_flags_t;

   function automatic fp_class_e fp_classify(input logic [31:0] word);
      logic [exp_width-1:0]  e;
      logic [frac_width-1:0] f;
      e = word[frac_width +: exp_width];
      f = word[frac_width-1:0];
      if (e == '0) return cls_zero;                     // subnormal -> zero
      if (e == '1) return (f == '0) ? cls_inf : cls_nan;
      return cls_normal;
   endfunction

endpackage

// File: src/fp_addsub_unit.sv
`timescale 1ns/10ps
module fp_addsub_unit
   import fpu_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic [31:0] floating_point1,
   input  logic [31:0] floating_point2,
   input  logic [6:0]  funct7,
   output fp_inter_t   addsub_res
);

   fp_class_e                    cls_a, cls_b;
   logic                         sign_a, sign_b;      // sign_b already flipped for sub
   logic [exp_width-1:0]         exp_a, exp_b;
   logic [frac_width-1:0]        frac_a, frac_b;
   logic [30:0]                  mag_a, mag_b;        // magnitude for the swap compare
   logic [inter_man_width-1:0]   sig_a, sig_b;
   logic                         swap;
   logic                         eff_sub;
   logic                         sign_big;
   logic [exp_width-1:0]         exp_big, exp_small;
   logic [inter_man_width-1:0]   sig_big, sig_small, sig_shift;
   logic [exp_width-1:0]         exp_diff;
   logic [4:0]                   shamt;
   logic [2*inter_man_width-1:0] align;
   logic                         align_sticky;
   logic [inter_man_width:0]     sum;                 // lsb carries sticky through the op
   fp_inter_t                    res_d;

   assign cls_a  = fp_classify(floating_point1);
   assign cls_b  = fp_classify(floating_point2);
   assign sign_a = floating_point1[31];
   assign sign_b = floating_point2[31] ^ (funct7 == op_sub);
   assign exp_a  = floating_point1[frac_width +: exp_width];
   assign exp_b  = floating_point2[frac_width +: exp_width];
   assign frac_a = floating_point1[frac_width-1:0];
   assign frac_b = floating_point2[frac_width-1:0];

   // zero class drops the fraction so subnormals vanish
   assign mag_a = (cls_a == cls_zero) ? '0 : floating_point1[30:0];
   assign mag_b = (cls_b == cls_zero) ? '0 : floating_point2[30:0];
   assign sig_a = (cls_a == cls_zero) ? '0 : {2'b01, frac_a, 2'b00};
   assign sig_b = (cls_b == cls_zero) ? '0 : {2'b01, frac_b, 2'b00};

   // larger magnitude goes first
   assign swap      = mag_b > mag_a;
   assign eff_sub   = sign_a ^ sign_b;
   assign sign_big  = swap ? sign_b : sign_a;
   assign exp_big   = swap ? exp_b : exp_a;
   assign exp_small = swap ? exp_a : exp_b;
   assign sig_big   = swap ? sig_b : sig_a;
   assign sig_small = swap ? sig_a : sig_b;

   // align small operand, anything past the round bit folds into sticky
   assign exp_diff = exp_big - exp_small;
   assign shamt    = (exp_diff >= exp_width'(inter_man_width)) ? 5'(inter_man_width)
                                                               : exp_diff[4:0];
   assign align        = {sig_small, {inter_man_width{1'b0}}} >> shamt;
   assign sig_shift    = align[2*inter_man_width-1:inter_man_width];
   assign align_sticky = |align[inter_man_width-1:0];

   // sticky as a third low bit keeps rne right after a 1-bit renormalize
   assign sum = eff_sub ? {sig_big, 1'b0} - {sig_shift, align_sticky}
                        : {sig_big, 1'b0} + {sig_shift, align_sticky};

   always_comb begin
      res_d             = '0;
      res_d.sign        = sign_big;
      res_d.cls         = cls_normal;
      res_d.exponent    = inter_exp_width'(exp_big);   // normalized later
      res_d.significand = sum[inter_man_width:1];
      res_d.sticky      = sum[0];
      if (cls_a == cls_nan || cls_b == cls_nan) begin
         res_d.cls = cls_nan;                           // quiet propagate, no nv
      end else if (cls_a == cls_inf && cls_b == cls_inf) begin
         res_d.cls     = eff_sub ? cls_nan : cls_inf;   // inf-inf is invalid
         res_d.invalid = eff_sub;
         res_d.sign    = sign_a;
      end else if (cls_a == cls_inf || cls_b == cls_inf) begin
         res_d.cls  = cls_inf;
         res_d.sign = (cls_a == cls_inf) ? sign_a : sign_b;
      end else if (cls_a == cls_zero && cls_b == cls_zero) begin
         res_d.cls  = cls_zero;
         res_d.sign = sign_a & sign_b;                  // only -0 + -0 stays negative
      end else if (sum == '0) begin
         res_d.cls  = cls_zero;                         // exact cancel -> +0
         res_d.sign = 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         addsub_res <= '0;   // cls_zero
      end else begin
         addsub_res <= res_d;
      end
   end

   // normal class never leaves with an empty significand
   a_normal_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
      addsub_res.cls == cls_normal |-> addsub_res.significand != '0);

endmodule

// File: src/fp_mul_unit.sv
`timescale 1ns/10ps
module fp_mul_unit
   import fpu_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic [31:0] floating_point1,
   input  logic [31:0] floating_point2,
   input  logic [6:0]  funct7,
   output fp_inter_t   mul_res
);

   fp_class_e                         cls_a, cls_b;
   logic                              sign_p;
   logic [exp_width-1:0]              exp_a, exp_b;
   logic [frac_width:0]               sig_a, sig_b;   // hidden bit on top
   logic [2*frac_width+1:0]           prod;           // [47] carry, [46] hidden
   logic signed [inter_exp_width-1:0] exp_sum;
   logic                              any_zero, any_inf;
   fp_inter_t                         res_d;

   assign cls_a  = fp_classify(floating_point1);
   assign cls_b  = fp_classify(floating_point2);
   assign sign_p = floating_point1[31] ^ floating_point2[31];
   assign exp_a  = floating_point1[frac_width +: exp_width];
   assign exp_b  = floating_point2[frac_width +: exp_width];
   assign sig_a  = {1'b1, floating_point1[frac_width-1:0]};
   assign sig_b  = {1'b1, floating_point2[frac_width-1:0]};

   assign prod    = sig_a * sig_b;
   assign exp_sum = inter_exp_width'(exp_a) + inter_exp_width'(exp_b)
                    - inter_exp_width'(exp_bias);   // may go negative, caught in round

   assign any_zero = (cls_a == cls_zero) || (cls_b == cls_zero);
   assign any_inf  = (cls_a == cls_inf) || (cls_b == cls_inf);

   always_comb begin
      res_d             = '0;
      res_d.sign        = sign_p;
      res_d.cls         = cls_normal;
      res_d.exponent    = exp_sum;
      // top 27 bits line up with the adder's layout
      res_d.significand = prod[$high(prod) -: inter_man_width];
      res_d.sticky      = |prod[$high(prod)-inter_man_width:0];   // low product bits
      if (cls_a == cls_nan || cls_b == cls_nan) begin
         res_d.cls = cls_nan;
      end else if (any_inf && any_zero) begin
         res_d.cls     = cls_nan;   // inf * 0
         res_d.invalid = 1'b1;
      end else if (any_inf) begin
         res_d.cls = cls_inf;
      end else if (any_zero) begin
         res_d.cls = cls_zero;      // signed zero
      end
   end

   // only loads on multiply, holds otherwise to cut toggling
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         mul_res <= '0;
      end else if (funct7 == op_mul) begin
         mul_res <= res_d;
      end
   end

   a_invalid_is_nan: assert property (@(posedge clk) disable iff (!rst_n)
      mul_res.invalid |-> mul_res.cls == cls_nan);

endmodule

// File: src/fp_round_pack.sv
`timescale 1ns/10ps
module fp_round_pack
   import fpu_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic [6:0]  funct7,
   input  fp_inter_t   addsub_res,
   input  fp_inter_t   mul_res,
   output logic [31:0] floating_point_out,
   output fpu_flags_t  flags
);

   fpu_op_e                           op_dec, op_q;
   fp_inter_t                         sel;
   logic [4:0]                        lz;
   logic [inter_man_width-1:0]        sig_n;
   logic                              sticky_n;
   logic signed [inter_exp_width-1:0] exp_n, exp_r;
   logic                              lsb, guard, rest, round_up;
   logic [frac_width+1:0]             mant_r;   // hidden + frac + rounding carry
   logic [31:0]                       word_d;
   fpu_flags_t                        flags_d;

   // zeros above the first one, hidden bit position downward
   function automatic logic [4:0] lead_zeros(input logic [inter_man_width-2:0] sig);
      logic [4:0] n;
      logic       found;
      n     = '0;
      found = 1'b0;
      for (int i = inter_man_width - 2; i >= 0; i--) begin
         if (sig[i]) found = 1'b1;
         else if (!found) n = n + 5'd1;
      end
      return n;
   endfunction

   always_comb begin
      case (funct7)
         op_add:  op_dec = op_add;
         op_sub:  op_dec = op_sub;
         op_mul:  op_dec = op_mul;
         default: op_dec = op_invalid;
      endcase
   end

   assign sel = (op_q == op_mul) ? mul_res : addsub_res;   // same stage as units

   // normalize: one right shift on carry, else left by lz
   always_comb begin
      lz = lead_zeros(sel.significand[inter_man_width-2:0]);
      if (sel.significand[inter_man_width-1]) begin
         sig_n    = sel.significand >> 1;
         sticky_n = sel.sticky | sel.significand[0];
         exp_n    = sel.exponent + inter_exp_width'(1);
      end else begin
         sig_n    = sel.significand << lz;
         sticky_n = sel.sticky;
         exp_n    = sel.exponent - inter_exp_width'(lz);
      end
   end

   // round to nearest, ties to even
   assign lsb      = sig_n[2];
   assign guard    = sig_n[1];
   assign rest     = sig_n[0] | sticky_n;
   assign round_up = guard & (rest | lsb);
   assign mant_r   = {1'b0, sig_n[inter_man_width-2:2]} + (frac_width+2)'(round_up);
   // carry out leaves frac all zero, so only exp moves
   assign exp_r    = mant_r[frac_width+1] ? exp_n + inter_exp_width'(1) : exp_n;

   always_comb begin
      word_d  = '0;
      flags_d = '0;
      if (op_q == op_invalid) begin
         word_d     = canonical_nan;
         flags_d.nv = 1'b1;
      end else begin
         case (sel.cls)
            cls_nan: begin
               word_d     = canonical_nan;
               flags_d.nv = sel.invalid;   // nan input stays quiet
            end
            cls_inf:  word_d = {sel.sign, {exp_width{1'b1}}, {frac_width{1'b0}}};
            cls_zero: word_d = {sel.sign, 31'd0};
            default: begin
               if (exp_r >= (1 << exp_width) - 1) begin
                  word_d     = {sel.sign, {exp_width{1'b1}}, {frac_width{1'b0}}};
                  flags_d.of = 1'b1;
                  flags_d.nx = 1'b1;
               end else if (exp_r < 1) begin
                  word_d     = {sel.sign, 31'd0};   // flush, no subnormals
                  flags_d.uf = 1'b1;
                  flags_d.nx = 1'b1;
               end else begin
                  word_d     = {sel.sign, exp_r[exp_width-1:0], mant_r[frac_width-1:0]};
                  flags_d.nx = guard | rest;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         op_q               <= op_add;
         floating_point_out <= '0;
         flags              <= '0;
      end else begin
         op_q               <= op_dec;
         floating_point_out <= word_d;
         flags              <= flags_d;
      end
   end

   a_of_nx: assert property (@(posedge clk) disable iff (!rst_n) flags.of |-> flags.nx);
   a_uf_nx: assert property (@(posedge clk) disable iff (!rst_n) flags.uf |-> flags.nx);

endmodule

// File: src/fpu_top_level.sv
`timescale 1ns/10ps
module fpu_top_level
   import fpu_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic [31:0] floating_point1,
   input  logic [31:0] floating_point2,
   input  logic [6:0]  funct7,
   output logic [31:0] floating_point_out,
   output fpu_flags_t  flags
);

   fp_inter_t addsub_res;   // stage 1 results
   fp_inter_t mul_res;

   fp_addsub_unit u_addsub (
      .clk             (clk),
      .rst_n           (rst_n),
      .floating_point1 (floating_point1),
      .floating_point2 (floating_point2),
      .funct7          (funct7),
      .addsub_res      (addsub_res)
   );

   fp_mul_unit u_mul (
      .clk             (clk),
      .rst_n           (rst_n),
      .floating_point1 (floating_point1),
      .floating_point2 (floating_point2),
      .funct7          (funct7),
      .mul_res         (mul_res)
   );

   // op decode registered in here, lines up with the unit regs
   fp_round_pack u_round_pack (
      .clk                (clk),
      .rst_n              (rst_n),
      .funct7             (funct7),
      .addsub_res         (addsub_res),
      .mul_res            (mul_res),
      .floating_point_out (floating_point_out),
      .flags              (flags)
   );

endmodule

// File: bench/fp_ref_model.svh
`ifndef FP_REF_MODEL_SVH
`define FP_REF_MODEL_SVH

// exact real value of a single word, subnormals read as zero
function automatic real word_to_real(input logic [31:0] w);
   if (w[30:23] == 8'h00) return 0.0;
   return $bitstoreal({w[31], 11'(w[30:23]) + 11'd896, w[22:0], 29'd0});   // rebias 127 -> 1023
endfunction

// rne to 24 bits with unbounded exponent, then range check and flush
task automatic pack_single(input real r, output logic [31:0] word, output fpu_flags_t flg);
   logic [63:0] d;
   logic [24:0] keep;   // rounding carry, hidden, 23 frac
   logic        g, s;
   int          e;
   d    = $realtobits(r);
   keep = {2'b01, d[51:29]};
   g    = d[28];
   s    = |d[27:0];
   e    = int'(d[62:52]) - 1023 + 127;
   flg  = '0;
   if (g && (s || keep[0])) keep = keep + 25'd1;   // ties to even
   if (keep[24]) begin
      keep = keep >> 1;
      e    = e + 1;
   end
   if (e >= 255) begin
      word   = {d[63], 8'hff, 23'd0};
      flg.of = 1'b1;
      flg.nx = 1'b1;
   end else if (e < 1) begin
      word   = {d[63], 31'd0};   // flushed, no subnormal results
      flg.uf = 1'b1;
      flg.nx = 1'b1;
   end else begin
      word   = {d[63], 8'(e), keep[22:0]};
      flg.nx = g | s;
   end
endtask

// expected word and flags for one operation
task automatic model_op(input logic [31:0] a, input logic [31:0] b, input logic [6:0] f7,
                        output logic [31:0] word, output fpu_flags_t flg);
   logic nan_in, a_inf, b_inf, a_zero, b_zero, sb;
   real  r;
   nan_in = (a[30:23] == 8'hff && a[22:0] != 0) || (b[30:23] == 8'hff && b[22:0] != 0);
   a_inf  = a[30:0] == {8'hff, 23'd0};
   b_inf  = b[30:0] == {8'hff, 23'd0};
   a_zero = a[30:23] == 8'h00;
   b_zero = b[30:23] == 8'h00;
   sb     = b[31] ^ (f7 == op_sub);   // effective sign of b
   word   = '0;
   flg    = '0;
   if (f7 != op_add && f7 != op_sub && f7 != op_mul) begin
      word   = 32'h7fc00000;
      flg.nv = 1'b1;
   end else if (nan_in) begin
      word = 32'h7fc00000;   // quiet, nv stays low
   end else if (f7 == op_mul) begin
      if ((a_inf && b_zero) || (a_zero && b_inf)) begin
         word   = 32'h7fc00000;
         flg.nv = 1'b1;
      end else if (a_inf || b_inf) begin
         word = {a[31] ^ b[31], 8'hff, 23'd0};
      end else if (a_zero || b_zero) begin
         word = {a[31] ^ b[31], 31'd0};
      end else begin
         pack_single(word_to_real(a) * word_to_real(b), word, flg);   // 48 bits, exact
      end
   end else if (a_inf && b_inf && a[31] != sb) begin
      word   = 32'h7fc00000;
      flg.nv = 1'b1;
   end else if (a_inf || b_inf) begin
      word = {a_inf ? a[31] : sb, 8'hff, 23'd0};
   end else if (a_zero && b_zero) begin
      word = {a[31] & sb, 31'd0};
   end else begin
      r = word_to_real(a) + word_to_real({sb, b[30:0]});
      if (r == 0.0) word = '0;   // exact cancel gives +0
      else pack_single(r, word, flg);
   end
endtask

`endif

// File: bench/tb_fpu_top_level.sv
`timescale 1ns/10ps
module tb_fpu_top_level
   import fpu_pkg::*;
();

   localparam int reset_cycles = 8;
   localparam int drain_limit  = 8;     // edges allowed to retire the last ops
   localparam int random_ops   = 400;

   typedef struct packed {
      logic [31:0] cyc;    // falling edge the op was driven on
      logic [31:0] word;
      fpu_flags_t  flg;
   } expect_t;

   logic        clk;
   logic        rst_n;
   logic [31:0] floating_point1;
   logic [31:0] floating_point2;
   logic [6:0]  funct7;
   logic [31:0] floating_point_out;
   fpu_flags_t  flags;
   expect_t     pend_q[$];   // ops in flight, oldest first
   int          cyc;

   `include "fp_ref_model.svh"

   fpu_top_level dut (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected) else begin
         $display("Error at %0t: %s expected %h, actual %h", $time, name, expected, actual);
         $display("Testbench failed");
         $fatal(1);
      end
   endtask

   // one falling edge, op driven two edges back is due here
   task automatic next_edge();
      expect_t e;
      @(negedge clk);
      cyc++;
      if (pend_q.size() > 0 && pend_q[0].cyc == 32'(cyc - 2)) begin
         e = pend_q.pop_front();
         check_value("floating_point_out", e.word, floating_point_out);
         check_value("flags", {27'd0, e.flg}, {27'd0, flags});
      end
   endtask

   task automatic apply_op(input logic [31:0] a, input logic [31:0] b, input logic [6:0] f7);
      expect_t e;
      next_edge();
      floating_point1 = a;
      floating_point2 = b;
      funct7          = f7;
      e.cyc           = cyc;
      model_op(a, b, f7, e.word, e.flg);
      pend_q.push_back(e);
   endtask

   // random normal word, biased exponent in lo .. lo+span
   function automatic logic [31:0] rand_word(input int lo, input int span);
      logic [7:0] e;
      e = 8'(lo + int'($urandom % (span + 1)));
      return {1'($urandom), e, 23'($urandom)};
   endfunction

   initial begin
      logic [31:0] a;
      int          pick;
      int          waited;
      void'($urandom(32'h9be51c79));
      rst_n           = 1'b0;
      floating_point1 = '0;
      floating_point2 = '0;
      funct7          = '0;
      cyc             = 0;
      for (int i = 0; i < reset_cycles; i++) begin   // outputs held at zero
         @(negedge clk);
         check_value("floating_point_out", '0, floating_point_out);
         check_value("flags", '0, {27'd0, flags});
      end
      rst_n = 1'b1;

      // 9.75 / 0.5625 and 92.7 / 27.4 pairs
      apply_op(32'h411c0000, 32'h3f100000, op_add);
      apply_op(32'h411c0000, 32'h3f100000, op_sub);
      apply_op(32'h3f100000, 32'h411c0000, op_sub);
      apply_op(32'hc11c0000, 32'h3f100000, op_add);
      apply_op(32'h42b96666, 32'h41db3333, op_add);
      apply_op(32'h41db3333, 32'h42b96666, op_sub);
      apply_op(32'hc2b96666, 32'hc1db3333, op_add);
      apply_op(32'h3fc00000, 32'h3fc00000, op_add);   // carry out of hidden bit
      apply_op(32'h3f800001, 32'h3f800000, op_sub);   // deep cancellation
      apply_op(32'h40000000, 32'h3fffffff, op_sub);
      // special operands
      apply_op(32'h7f800000, 32'h7f800000, op_sub);   // inf - inf
      apply_op(32'h7f800000, 32'h00000000, op_mul);   // inf * 0
      apply_op(32'hff800000, 32'h40400000, op_add);
      apply_op(32'h80000000, 32'h80000000, op_add);   // -0 + -0
      apply_op(32'h42b96666, 32'h42b96666, op_sub);   // x - x
      apply_op(32'h7fc00000, 32'h3f800000, op_add);
      apply_op(32'h40000000, 32'h7f800001, op_mul);   // signaling nan
      apply_op(32'h00000123, 32'h3f800000, op_add);   // subnormal in
      // range limits
      apply_op(32'h7f000000, 32'h7f000000, op_mul);
      apply_op(32'hff000000, 32'h7f000000, op_mul);
      apply_op(32'h80800000, 32'h0c000000, op_mul);
      apply_op(32'h3f800000, 32'h3f800000, 7'b0101100);   // unsupported funct7

      // back to back mix, exponents kept clear of of/uf
      for (int i = 0; i < random_ops; i++) begin
         pick = $urandom % 3;
         if (pick == 2) begin
            a = rand_word(70, 110);
            apply_op(a, rand_word(70, 110), op_mul);
         end else begin
            a = rand_word(100, 50);
            apply_op(a, rand_word(int'(a[30:23]) - 28, 56), pick == 1 ? op_sub : op_add);
         end
      end

      waited = 0;
      while (pend_q.size() > 0 && waited < drain_limit) begin
         next_edge();
         waited++;
      end
      if (pend_q.size() == 0) begin
         $display("Testbench passed");
         $finish;
      end else begin
         $display("results still pending after %0d drain cycles", drain_limit);
         $display("Testbench failed");
         $fatal(1);
      end
   end

endmodule

// File: flist.f
+incdir+bench
src/fpu_pkg.sv
src/fp_addsub_unit.sv
src/fp_mul_unit.sv
src/fp_round_pack.sv
src/fpu_top_level.sv
bench/tb_fpu_top_level.sv
